// ==== logic/kicker_rom_pkg.sv ====
// Shared widths, memory map and types for the ROM download and slot read path
package kicker_rom_pkg;

    // Bus widths
    localparam int LOAD_AW = 16;
    localparam int WORD_AW = 12;
    localparam int MAIN_AW = 13;
    localparam int SCR_AW  = 10;
    localparam int PROM_AW = 8;

    // Store depth follows the word address width
    localparam int STORE_WORDS = 2**WORD_AW;

    typedef logic [LOAD_AW-1:0] load_addr_t;   // Loader byte address
    typedef logic [WORD_AW-1:0] word_addr_t;   // Store word address
    typedef logic [7:0]         byte_t;
    typedef logic [15:0]        word_t;        // One store word, two byte lanes
    typedef logic [31:0]        scr_data_t;    // Scroll slot, high word first
    typedef logic [MAIN_AW-1:0] main_addr_t;   // Main slot byte address
    typedef logic [SCR_AW-1:0]  scr_addr_t;    // Scroll slot, 32-bit units
    typedef logic [PROM_AW-1:0] prom_addr_t;

    // Loader memory map in bytes
    // Main CPU code sits below SCR_START
    localparam load_addr_t SCR_START  = 16'h2000;
    localparam load_addr_t PROM_START = 16'h2800;
    localparam load_addr_t PROM_END   = 16'h2900;  // First byte past the PROMs

    // Lane masks, active low
    localparam logic [1:0] MASK_LO = 2'b10;  // Even byte
    localparam logic [1:0] MASK_HI = 2'b01;  // Odd byte

    // Store write request, 30 bits
    typedef struct packed {
        word_addr_t addr;
        word_t      data;  // Loader byte in both lanes
        logic [1:0] mask;  // Lane enables, active low
    } store_wr_t;

    // Slot reader FSM
    typedef enum logic [1:0] {
        IDLE,
        MAIN_RD,
        SCR_LO,
        SCR_HI
    } slot_state_t;

endpackage

// ==== logic/kicker_rom_top.sv ====
// Top of the ROM path: loader download, ROM store and read slots for the game core
`timescale 1ns/100ps

module kicker_rom_top (
    input  logic                       clk,
    input  logic                       arst_n,
    // Loader
    input  logic                       downloading,
    input  kicker_rom_pkg::load_addr_t ioctl_addr,
    input  kicker_rom_pkg::byte_t      ioctl_dout,
    input  logic                       ioctl_wr,
    // Colour PROMs
    output logic                       prom_we,
    output kicker_rom_pkg::prom_addr_t prom_addr,
    output kicker_rom_pkg::byte_t      prom_data,
    // Main CPU slot
    input  logic                       main_cs,
    input  kicker_rom_pkg::main_addr_t main_addr,
    output kicker_rom_pkg::byte_t      main_data,
    output logic                       main_ok,
    // Scroll slot
    input  logic                       scr_cs,
    input  kicker_rom_pkg::scr_addr_t  scr_addr,
    output kicker_rom_pkg::scr_data_t  scr_data,
    output logic                       scr_ok
);
    import kicker_rom_pkg::*;

    store_wr_t  wr;
    logic       wr_stb;
    word_addr_t rd_addr;
    word_t      rd_data;

    rom_dwnld u_dwnld (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .wr          ( wr          ),
        .wr_stb      ( wr_stb      ),
        .prom_we     ( prom_we     ),
        .prom_addr   ( prom_addr   ),
        .prom_data   ( prom_data   )
    );

    rom_store u_store (
        .clk         ( clk         ),
        .wr          ( wr          ),
        .wr_stb      ( wr_stb      ),
        .rd_addr     ( rd_addr     ),
        .rd_data     ( rd_data     )
    );

    rom_slots u_slots (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .main_cs     ( main_cs     ),
        .main_addr   ( main_addr   ),
        .main_data   ( main_data   ),
        .main_ok     ( main_ok     ),
        .scr_cs      ( scr_cs      ),
        .scr_addr    ( scr_addr    ),
        .scr_data    ( scr_data    ),
        .scr_ok      ( scr_ok      ),
        .rd_addr     ( rd_addr     ),
        .rd_data     ( rd_data     )
    );

endmodule

// ==== logic/rom_dwnld.sv ====
// Download unit: sorts loader bytes into masked store writes and colour PROM strobes
`timescale 1ns/100ps

module rom_dwnld (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       downloading,
    input  kicker_rom_pkg::load_addr_t ioctl_addr,
    input  kicker_rom_pkg::byte_t      ioctl_dout,
    input  logic                       ioctl_wr,
    output kicker_rom_pkg::store_wr_t  wr,
    output logic                       wr_stb,
    output logic                       prom_we,
    output kicker_rom_pkg::prom_addr_t prom_addr,
    output kicker_rom_pkg::byte_t      prom_data
);
    import kicker_rom_pkg::*;

    logic       take;
    logic       in_main;
    logic       in_scr;
    logic       in_prom;
    word_addr_t pre_addr;
    word_addr_t sw_addr;
    load_addr_t prom_off;
    store_wr_t  wr_nx;

    assign take = downloading && ioctl_wr;  // Strobes outside a download are dropped

    // Region decode
    assign in_main = ioctl_addr < SCR_START;
    assign in_scr  = (ioctl_addr >= SCR_START) && (ioctl_addr < PROM_START);
    assign in_prom = (ioctl_addr >= PROM_START) && (ioctl_addr < PROM_END);

    // Byte address halved into the 4K-word store
    // Scroll tiles wrap onto the low store words
    assign pre_addr = ioctl_addr[WORD_AW:1];

    assign prom_off = ioctl_addr - PROM_START;

    // Tile address lines are swapped on the original board
    always_comb begin
        sw_addr = pre_addr;
        if (in_scr) begin
            sw_addr[0]   = ~pre_addr[3];
            sw_addr[3:1] = pre_addr[2:0];
        end
    end

    always_comb begin
        wr_nx.addr = sw_addr;
        wr_nx.data = {ioctl_dout, ioctl_dout};
        wr_nx.mask = ioctl_addr[0] ? MASK_HI : MASK_LO;  // Odd byte to the high lane
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_stb  <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            wr_stb  <= take && (in_main || in_scr);
            prom_we <= take && in_prom;
        end
    end

    // Payload follows every accepted byte
    always_ff @(posedge clk) begin
        if (take) begin
            wr        <= wr_nx;
            prom_addr <= prom_off[PROM_AW-1:0];
            prom_data <= ioctl_dout;
        end
    end

endmodule

// ==== logic/rom_slots.sv ====
// Slot reader: serves the main and scroll read clients from the ROM store after download
`timescale 1ns/100ps

module rom_slots (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       downloading,
    input  logic                       main_cs,
    input  kicker_rom_pkg::main_addr_t main_addr,
    output kicker_rom_pkg::byte_t      main_data,
    output logic                       main_ok,
    input  logic                       scr_cs,
    input  kicker_rom_pkg::scr_addr_t  scr_addr,
    output kicker_rom_pkg::scr_data_t  scr_data,
    output logic                       scr_ok,
    output kicker_rom_pkg::word_addr_t rd_addr,
    input  kicker_rom_pkg::word_t      rd_data
);
    import kicker_rom_pkg::*;

    slot_state_t state;

    main_addr_t main_cur;   // Address being read
    main_addr_t main_last;  // Last address served
    logic       main_vld;
    logic       main_pend;

    scr_addr_t  scr_cur;
    scr_addr_t  scr_last;
    logic       scr_vld;
    logic       scr_pend;

    // Word address of one half of a scroll entry
    function automatic word_addr_t scr_word(input scr_addr_t addr, input logic half);
        word_addr_t base;
        base     = SCR_START[WORD_AW:1];
        scr_word = base + word_addr_t'({addr, half});
    endfunction

    assign main_pend = main_cs && (!main_vld || main_addr != main_last);
    assign scr_pend  = scr_cs && (!scr_vld || scr_addr != scr_last);

    // Level ok flags, held while the client keeps cs and address
    assign main_ok = !downloading && main_cs && main_vld && (main_addr == main_last);
    assign scr_ok  = !downloading && scr_cs && scr_vld && (scr_addr == scr_last);

    // Store address, scroll first
    always_comb begin
        if (state == SCR_LO) begin
            rd_addr = scr_word(scr_cur, 1'b1);  // High half follows the low one
        end else if (scr_pend) begin
            rd_addr = scr_word(scr_addr, 1'b0);
        end else begin
            rd_addr = main_addr[MAIN_AW-1:1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            main_vld  <= 1'b0;
            main_last <= '0;
            scr_vld   <= 1'b0;
            scr_last  <= '0;
        end else if (downloading) begin
            state    <= IDLE;  // Store contents are changing
            main_vld <= 1'b0;
            scr_vld  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (scr_pend) begin
                        state <= SCR_LO;
                    end else if (main_pend) begin
                        state <= MAIN_RD;
                    end
                end
                MAIN_RD: begin
                    main_last <= main_cur;
                    main_vld  <= 1'b1;
                    state     <= IDLE;
                end
                SCR_LO: begin
                    state <= SCR_HI;
                end
                SCR_HI: begin
                    scr_last <= scr_cur;
                    scr_vld  <= 1'b1;
                    state    <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Request capture and data assembly
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            if (scr_pend) begin
                scr_cur <= scr_addr;
            end else if (main_pend) begin
                main_cur <= main_addr;
            end
        end
        if (state == MAIN_RD) begin
            main_data <= main_cur[0] ? rd_data[15:8] : rd_data[7:0];  // Lane by byte parity
        end
        if (state == SCR_LO) begin
            scr_data[15:0] <= rd_data;
        end
        if (state == SCR_HI) begin
            scr_data[31:16] <= rd_data;
        end
    end

endmodule

// ==== logic/rom_store.sv ====
// ROM store: on-chip word memory standing in for SDRAM, byte-lane writes and one read port
`timescale 1ns/100ps

module rom_store (
    input  logic                       clk,
    input  kicker_rom_pkg::store_wr_t  wr,
    input  logic                       wr_stb,
    input  kicker_rom_pkg::word_addr_t rd_addr,
    output kicker_rom_pkg::word_t      rd_data
);
    import kicker_rom_pkg::*;

    word_t mem [STORE_WORDS];

    // Write port, only lanes with a low mask bit change
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (wr_stb && !wr.mask[i]) begin
                mem[wr.addr][i*8 +: 8] <= wr.data[i*8 +: 8];
            end
        end
    end

    // Read port
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];  // Valid one cycle after rd_addr
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ROM path testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_kicker_rom -Mdir obj_dir \
    && ./obj_dir/Vtb_kicker_rom +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qF "** PASS **" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== sources.f ====
logic/kicker_rom_pkg.sv
logic/rom_dwnld.sv
logic/rom_store.sv
logic/rom_slots.sv
logic/kicker_rom_top.sv
testbench/rom_properties.sv
testbench/rom_checker.sv
testbench/tb_kicker_rom.sv

// ==== testbench/rom_checker.sv ====
// Reference model of the ROM path; compares PROM strobes and slot reads with the loader image
`timescale 1ns/100ps

module rom_checker (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       downloading,
    input  kicker_rom_pkg::load_addr_t ioctl_addr,
    input  kicker_rom_pkg::byte_t      ioctl_dout,
    input  logic                       ioctl_wr,
    input  logic                       prom_we,
    input  kicker_rom_pkg::prom_addr_t prom_addr,
    input  kicker_rom_pkg::byte_t      prom_data,
    input  logic                       main_cs,
    input  kicker_rom_pkg::main_addr_t main_addr,
    input  kicker_rom_pkg::byte_t      main_data,
    input  logic                       main_ok,
    input  logic                       scr_cs,
    input  kicker_rom_pkg::scr_addr_t  scr_addr,
    input  kicker_rom_pkg::scr_data_t  scr_data,
    input  logic                       scr_ok,
    output int                         value_errs,
    output int                         proto_errs
);
    import kicker_rom_pkg::*;

    word_t      image [4096];  // Model of the store contents
    logic       exp_we;
    prom_addr_t exp_paddr;
    byte_t      exp_pdata;
    logic       prev_main_ok;
    main_addr_t prev_main_addr;
    logic       prev_scr_ok;
    scr_addr_t  prev_scr_addr;

    // Store word for a loader byte, tile lines swapped in the scroll region
    function automatic word_addr_t store_index(input load_addr_t a);
        logic [15:0] w;
        w = a >> 1;
        if ((a >= SCR_START) && (a < PROM_START)) begin
            w[3:0] = {w[2:0], ~w[3]};
        end
        return w[11:0];
    endfunction

    initial begin
        value_errs   = 0;
        proto_errs   = 0;
        exp_we       = 1'b0;
        prev_main_ok = 1'b0;
        prev_scr_ok  = 1'b0;
    end

    always @(posedge clk) begin
        load_addr_t pa;
        word_addr_t idx;
        word_addr_t lo;
        word_addr_t hi;
        word_t      w;
        byte_t      exp_b;
        scr_data_t  exp_s;
        if (arst_n) begin
            if (prom_we !== exp_we) begin
                $display("[FAIL] prom_we expected %h got %h at %0t", exp_we, prom_we, $time);
                value_errs++;
            end else if (exp_we && (prom_addr !== exp_paddr)) begin
                $display("[FAIL] prom_addr expected %h got %h", exp_paddr, prom_addr);
                value_errs++;
            end else if (exp_we && (prom_data !== exp_pdata)) begin
                $display("[FAIL] prom_data expected %h got %h", exp_pdata, prom_data);
                value_errs++;
            end
            pa        = ioctl_addr - PROM_START;
            exp_we    = downloading && ioctl_wr && (ioctl_addr >= PROM_START)
                        && (ioctl_addr < PROM_END);
            exp_paddr = pa[7:0];
            exp_pdata = ioctl_dout;
            if (downloading && ioctl_wr && (ioctl_addr < PROM_START)) begin
                idx = store_index(ioctl_addr);
                if (ioctl_addr[0]) begin
                    image[idx][15:8] = ioctl_dout;  // Odd byte, high lane
                end else begin
                    image[idx][7:0] = ioctl_dout;
                end
            end
            if (downloading && (main_ok || scr_ok)) begin
                $display("Read slot reported ok while the download was running at %0t", $time);
                proto_errs++;
            end
            if (prev_main_ok && main_cs && (main_addr == prev_main_addr)
                    && !downloading && !main_ok) begin
                $display("main_ok dropped while cs and address were held at %0t", $time);
                proto_errs++;
            end
            if (prev_scr_ok && scr_cs && (scr_addr == prev_scr_addr)
                    && !downloading && !scr_ok) begin
                $display("scr_ok dropped while cs and address were held at %0t", $time);
                proto_errs++;
            end
            if (main_ok) begin
                w     = image[main_addr[12:1]];
                exp_b = main_addr[0] ? w[15:8] : w[7:0];
                if (main_data !== exp_b) begin
                    $display("[FAIL] main_data @%h expected %h got %h", main_addr, exp_b,
                             main_data);
                    value_errs++;
                end
            end
            if (scr_ok) begin
                lo    = word_addr_t'((SCR_START >> 1) + 2 * scr_addr);  // Wraps to 12 bits
                hi    = lo + 12'd1;
                exp_s = {image[hi], image[lo]};
                if (scr_data !== exp_s) begin
                    $display("[FAIL] scr_data @%h expected %h got %h", scr_addr, exp_s,
                             scr_data);
                    value_errs++;
                end
            end
            prev_main_ok   = main_ok;
            prev_main_addr = main_addr;
            prev_scr_ok    = scr_ok;
            prev_scr_addr  = scr_addr;
        end
    end

endmodule

// ==== testbench/rom_patterns.hex ====
// Entry: kind[31:28], zero[27:24], address[23:8], data[7:0]
// Kind 1 loader byte, 2 main read, 3 scroll read, 4 main address plus scroll address[7:0], 0 end
// Main CPU bytes
10100011 10100122 10100233 10100344 10100455 10100566 10100677 10100788
101FFE5A 101FFFA5
// Scroll tiles
102000A0 102001A1 102002A2 102003A3 102004A4 102005A5 102006A6 102007A7
102008A8 102009A9 10200AAA 10200BAB 10200CAC 10200DAD 10200EAE 10200FAF
102010B0 102011B1 102012B2 102013B3 102014B4 102015B5 102016B6 102017B7
102018B8 102019B9 10201ABA 10201BBB 10201CBC 10201DBD 10201EBE 10201FBF
// Colour PROMs
10280050 10280151 10280252 10280353 10280454 10280555 10280656 10280757
1028FFEE
// Outside the regions, aliasing the main bytes
10300099 10300198 10290097 10F00796
// Reads
20100000 20100100 20100200 20100300 20100400 20100500 20100600 20100700
201FFE00 201FFF00
30000000 30000100 30000200 30000300 30000400 30000500 30000600 30000700
41000302 41000607 41FFFE00 41100104
00000000

// ==== testbench/rom_properties.sv ====
// Concurrent checks on the ROM path strobes and slot reader, bound into the top level
`timescale 1ns/100ps

module rom_properties (
    input logic                        clk,
    input logic                        arst_n,
    input logic                        downloading,
    input logic                        prom_we,
    input logic                        main_ok,
    input logic                        scr_ok,
    input kicker_rom_pkg::slot_state_t state
);
    import kicker_rom_pkg::*;

    int ok_fails    = 0;
    int we_fails    = 0;
    int order_fails = 0;

    ok_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        downloading |-> (!main_ok && !scr_ok))
        else begin
            ok_fails++;
            $error("ok flag high while the download is running");
        end

    // PROM write is a single-cycle strobe
    we_pulse: assert property (@(posedge clk) disable iff (!arst_n) prom_we |=> !prom_we)
        else begin
            we_fails++;
            $error("prom_we held for more than one cycle");
        end

    scr_order: assert property (@(posedge clk) disable iff (!arst_n)
        ((state == SCR_LO) && !downloading) |=> (state == SCR_HI))
        else begin
            order_fails++;
            $error("slot reader left SCR_LO without going to SCR_HI");
        end

endmodule

bind kicker_rom_top rom_properties props0 (
    .clk         ( clk            ),
    .arst_n      ( arst_n         ),
    .downloading ( downloading    ),
    .prom_we     ( prom_we        ),
    .main_ok     ( main_ok        ),
    .scr_ok      ( scr_ok         ),
    .state       ( u_slots.state  )
);

// ==== testbench/tb_kicker_rom.sv ====
// Testbench top for the ROM path: replays the pattern file through the loader and read slots
`timescale 1ns/100ps

module tb_kicker_rom;
    import kicker_rom_pkg::*;

    localparam int          PERIOD  = 40;
    localparam int          MAX_ENT = 128;
    localparam logic [31:0] SEED    = 32'he6f4;
    localparam int          CYC_PER = 12;  // Watchdog budget per byte or read

    logic       clk;
    logic       arst_n;
    logic       downloading;
    load_addr_t ioctl_addr;
    byte_t      ioctl_dout;
    logic       ioctl_wr;
    logic       prom_we;
    prom_addr_t prom_addr;
    byte_t      prom_data;
    logic       main_cs;
    main_addr_t main_addr;
    byte_t      main_data;
    logic       main_ok;
    logic       scr_cs;
    scr_addr_t  scr_addr;
    scr_data_t  scr_data;
    logic       scr_ok;
    int         value_errs;
    int         proto_errs;

    logic [31:0] pat [MAX_ENT];  // kind, address, data
    logic [31:0] loads[$];
    logic [31:0] reads[$];
    int          n_reads;
    bit          table_ready;

    kicker_rom_top dut0 (.*);

    rom_checker chk0 (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // One loader byte, then a random gap before the next strobe
    task automatic send_byte(input logic [31:0] ent);
        int gap;
        gap        = 2 + int'($urandom % 3);
        ioctl_addr = ent[23:8];
        ioctl_dout = ent[7:0];
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        repeat (gap - 1) @(negedge clk);
    endtask

    // Both slots at once when both cs are set
    task automatic read_slots(input logic use_main, input main_addr_t maddr,
                              input logic use_scr, input scr_addr_t saddr);
        bit seen_m;
        bit seen_s;
        seen_m    = !use_main;
        seen_s    = !use_scr;
        main_cs   = use_main;
        main_addr = maddr;
        scr_cs    = use_scr;
        scr_addr  = saddr;
        while (!(seen_m && seen_s)) begin
            @(negedge clk);
            seen_m = seen_m | main_ok;
            seen_s = seen_s | scr_ok;
        end
        repeat (2) @(negedge clk);  // Hold so ok must stay up
        main_cs = 1'b0;
        scr_cs  = 1'b0;
        @(negedge clk);
    endtask

    initial begin
        automatic int limit;
        wait (table_ready);
        limit = (loads.size() + n_reads) * CYC_PER;
        #(limit * PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        logic [31:0] tmp;
        int          i;
        int          j;
        int          asrt;
        arst_n = 1'b0;
        downloading = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        ioctl_wr = 1'b0;
        main_cs = 1'b0;
        main_addr = '0;
        scr_cs = 1'b0;
        scr_addr = '0;
        n_reads = 0;
        table_ready = 1'b0;
        tmp = $urandom(SEED);
        for (i = 0; i < MAX_ENT; i++) begin
            pat[i] = '0;
        end
        $readmemh("testbench/rom_patterns.hex", pat);
        for (i = 0; (i < MAX_ENT) && (pat[i][31:28] != 4'h0); i++) begin
            if (pat[i][31:28] == 4'h1) begin
                loads.push_back(pat[i]);
            end else begin
                reads.push_back(pat[i]);
                n_reads += (pat[i][31:28] == 4'h4) ? 2 : 1;
            end
        end
        n_reads += 4;  // Reload pass reads both slots twice
        for (i = reads.size() - 1; i > 0; i--) begin  // Shuffle the read order
            j = int'($urandom % (i + 1));
            tmp = reads[i];
            reads[i] = reads[j];
            reads[j] = tmp;
        end
        table_ready = 1'b1;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        downloading = 1'b1;
        main_cs = 1'b1;  // Requests that must wait for the end of the download
        main_addr = 13'h1000;
        scr_cs = 1'b1;
        foreach (loads[k]) begin
            send_byte(loads[k]);
        end
        downloading = 1'b0;
        main_cs = 1'b0;
        scr_cs = 1'b0;
        repeat (2) @(negedge clk);
        foreach (reads[k]) begin
            case (reads[k][31:28])
                4'h2: read_slots(1'b1, reads[k][20:8], 1'b0, '0);
                4'h3: read_slots(1'b0, '0, 1'b1, reads[k][17:8]);
                default: read_slots(1'b1, reads[k][20:8], 1'b1, {2'b00, reads[k][7:0]});
            endcase
        end
        // Served requests held into a new download
        read_slots(1'b1, 13'h1000, 1'b1, 10'h001);
        main_cs = 1'b1;  // Same addresses, ok comes back at once
        scr_cs = 1'b1;
        @(negedge clk);
        downloading = 1'b1;  // ok must drop while the store reloads
        repeat (3) @(negedge clk);
        downloading = 1'b0;
        read_slots(1'b1, 13'h1000, 1'b1, 10'h001);
        repeat (4) @(negedge clk);
        asrt = dut0.props0.ok_fails + dut0.props0.we_fails + dut0.props0.order_fails;
        $display("Errors: value %0d, protocol %0d, assertion %0d", value_errs, proto_errs, asrt);
        if ((value_errs + proto_errs + asrt) == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
